//--- design/matmul_config.svh
`ifndef MATMUL_CONFIG_SVH
`define MATMUL_CONFIG_SVH

// element width in bits
`define MATMUL_DWIDTH 8

// array is N x N, one memory lane per row or column
`define MATMUL_N 4

`define MATMUL_AWIDTH 7
`define MATMUL_MEM_DEPTH 128

// multiply stage plus accumulate stage
`define MATMUL_MAC_STAGES 2

`define MATMUL_WORD_WIDTH (`MATMUL_N * `MATMUL_DWIDTH)

`endif

//--- design/matmul_pkg.sv
`include "matmul_config.svh"

package matmul_pkg;

  // one matrix element, unsigned
  typedef logic [`MATMUL_DWIDTH-1:0] elem_t;

  // one memory word, lane k in bits [k*DWIDTH +: DWIDTH]
  typedef elem_t [`MATMUL_N-1:0] word_t;

  typedef logic [`MATMUL_AWIDTH-1:0] addr_t;

  // run sequencer
  typedef enum logic [2:0] {
    st_idle,
    st_feed,
    st_flush,
    st_write,
    st_done
  } seq_state_t;

endpackage

//--- design/word_ram.sv
`timescale 1ns/1ps
`include "matmul_config.svh"

module word_ram #(
  parameter int depth = `MATMUL_MEM_DEPTH
) (
  input  logic              clk,
  input  matmul_pkg::addr_t addr,
  input  matmul_pkg::word_t wdata,
  input  logic              we,
  output matmul_pkg::word_t rdata
);

  logic [`MATMUL_WORD_WIDTH-1:0] mem [depth];

  // read-before-write, so a read at the written address sees the old word
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- design/operand_decode.sv
`timescale 1ns/1ps
`include "matmul_config.svh"

module operand_decode (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic              write_done,
  input  matmul_pkg::word_t a_rdata,
  input  matmul_pkg::word_t b_rdata,
  output matmul_pkg::addr_t a_addr,
  output matmul_pkg::addr_t b_addr,
  output matmul_pkg::word_t a_feed,
  output matmul_pkg::word_t b_feed,
  output logic              acc_clear,
  output logic              capture,
  output logic              done
);

  import matmul_pkg::*;

  // counted from the first feed cycle: N reads, N-1 skew, then the flush
  localparam int capture_cnt = 2 * `MATMUL_N - 1 + 2 * (`MATMUL_N - 1) + `MATMUL_MAC_STAGES;
  localparam int cnt_width = $clog2(capture_cnt + 1);
  localparam addr_t park_addr = addr_t'(`MATMUL_MEM_DEPTH - 1);

  seq_state_t state;
  logic [cnt_width-1:0] cnt;
  addr_t rd_addr;
  logic rd_valid;
  word_t a_gated;
  word_t b_gated;

  // dropping start abandons the run from any state
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      state   <= st_idle;
      cnt     <= '0;
      rd_addr <= park_addr;
    end else begin
      case (state)
        st_idle: begin
          state   <= st_feed;
          cnt     <= '0;
          rd_addr <= '0;
        end
        st_feed: begin
          cnt <= cnt + 1'b1;
          if (cnt == cnt_width'(`MATMUL_N - 1)) begin
            state   <= st_flush;
            rd_addr <= park_addr;
          end else begin
            rd_addr <= rd_addr + 1'b1;
          end
        end
        st_flush: begin
          cnt <= cnt + 1'b1;
          if (capture) begin
            state <= st_write;
          end
        end
        st_write: begin
          if (write_done) begin
            state <= st_done;
          end
        end
        st_done: begin
          state <= st_done;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // read data comes back one cycle after a feed-state address
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= (state == st_feed);
    end
  end

  // parked-address contents must not reach the array
  assign a_gated = rd_valid ? a_rdata : '0;
  assign b_gated = rd_valid ? b_rdata : '0;

  // lane i delayed by i cycles so operands meet on the diagonal
  for (genvar i = 0; i < `MATMUL_N; i++) begin : g_skew
    if (i == 0) begin : g_lane0
      assign a_feed[0] = a_gated[0];
      assign b_feed[0] = b_gated[0];
    end else begin : g_delay
      elem_t a_pipe [i];
      elem_t b_pipe [i];

      always_ff @(posedge clk) begin
        if (reset) begin
          a_pipe <= '{default: '0};
          b_pipe <= '{default: '0};
        end else begin
          a_pipe[0] <= a_gated[i];
          b_pipe[0] <= b_gated[i];
          for (int s = 1; s < i; s++) begin
            a_pipe[s] <= a_pipe[s-1];
            b_pipe[s] <= b_pipe[s-1];
          end
        end
      end

      assign a_feed[i] = a_pipe[i-1];
      assign b_feed[i] = b_pipe[i-1];
    end
  end

  assign a_addr = rd_addr;
  assign b_addr = rd_addr;

  // clears the accumulators on the idle to feed edge
  assign acc_clear = (state == st_idle) && start;
  assign capture   = (state == st_flush) && (cnt == cnt_width'(capture_cnt));
  assign done      = (state == st_done);

  // the address register must track the feed state, never run past the matrix
  a_feed_addr_range: assert property (
    @(posedge clk) disable iff (reset)
    (state == st_feed) |-> (rd_addr < addr_t'(`MATMUL_N))
  );

endmodule

//--- design/mac_pe.sv
`timescale 1ns/1ps

module mac_pe (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::elem_t in_a,
  input  matmul_pkg::elem_t in_b,
  output matmul_pkg::elem_t out_a,
  output matmul_pkg::elem_t out_b,
  output matmul_pkg::elem_t sum
);

  import matmul_pkg::*;

  elem_t prod_q;
  elem_t acc_q;

  // operand forwarding to the right and down neighbours
  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // stage 1 keeps the low byte of the product, stage 2 accumulates mod 256
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_q <= '0;
      acc_q  <= '0;
    end else begin
      prod_q <= in_a * in_b;
      if (clear) begin
        acc_q <= '0;
      end else begin
        acc_q <= acc_q + prod_q;
      end
    end
  end

  assign sum = acc_q;

endmodule

//--- design/systolic_execute.sv
`timescale 1ns/1ps
`include "matmul_config.svh"

module systolic_execute (
  input  logic              clk,
  input  logic              reset,
  input  logic              acc_clear,
  input  matmul_pkg::word_t a_feed,
  input  matmul_pkg::word_t b_feed,
  output matmul_pkg::elem_t sums [`MATMUL_N * `MATMUL_N]
);

  import matmul_pkg::*;

  // a moves right along a row, b moves down a column
  elem_t a_link [`MATMUL_N][`MATMUL_N + 1];
  elem_t b_link [`MATMUL_N + 1][`MATMUL_N];

  for (genvar k = 0; k < `MATMUL_N; k++) begin : g_edge
    assign a_link[k][0] = a_feed[k];
    assign b_link[0][k] = b_feed[k];
  end

  for (genvar i = 0; i < `MATMUL_N; i++) begin : g_row
    for (genvar j = 0; j < `MATMUL_N; j++) begin : g_col
      mac_pe pe (
        .clk   (clk),
        .reset (reset),
        .clear (acc_clear),
        .in_a  (a_link[i][j]),
        .in_b  (b_link[i][j]),
        .out_a (a_link[i][j+1]),
        .out_b (b_link[i+1][j]),
        .sum   (sums[i * `MATMUL_N + j])
      );
    end
  end

endmodule

//--- design/result_store.sv
`timescale 1ns/1ps
`include "matmul_config.svh"

module result_store (
  input  logic              clk,
  input  logic              reset,
  input  logic              capture,
  input  matmul_pkg::elem_t sums [`MATMUL_N * `MATMUL_N],
  input  logic              read_en,
  input  matmul_pkg::addr_t host_addr,
  output logic              write_done,
  output matmul_pkg::word_t read_data
);

  import matmul_pkg::*;

  localparam int col_width = $clog2(`MATMUL_N);

  elem_t hold [`MATMUL_N * `MATMUL_N];
  logic wr_active;
  logic [col_width-1:0] wr_col;
  word_t c_wdata;
  addr_t c_addr;
  logic c_we;

  // snapshot of the array, row-major
  always_ff @(posedge clk) begin
    if (capture) begin
      hold <= sums;
    end
  end

  // one column per cycle, paused while the host reads
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_active  <= 1'b0;
      wr_col     <= '0;
      write_done <= 1'b0;
    end else begin
      write_done <= 1'b0;
      if (capture) begin
        wr_active <= 1'b1;
        wr_col    <= '0;
      end else if (wr_active && !read_en) begin
        wr_col <= wr_col + 1'b1;
        if (wr_col == col_width'(`MATMUL_N - 1)) begin
          wr_active  <= 1'b0;
          write_done <= 1'b1;
        end
      end
    end
  end

  // word j holds column j, lane i is row i
  always_comb begin
    for (int i = 0; i < `MATMUL_N; i++) begin
      c_wdata[i] = hold[i * `MATMUL_N + int'(wr_col)];
    end
  end

  assign c_we   = wr_active && !read_en;
  assign c_addr = read_en ? host_addr : addr_t'(wr_col);

  word_ram c_ram (
    .clk   (clk),
    .addr  (c_addr),
    .wdata (c_wdata),
    .we    (c_we),
    .rdata (read_data)
  );

  // a new capture would overwrite the snapshot mid write-out
  capture_not_during_write: assert property (
    @(posedge clk) disable iff (reset)
    capture |-> !wr_active
  );

endmodule

//--- design/matmul_top.sv
`timescale 1ns/1ps
`include "matmul_config.svh"

module matmul_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              load_en,
  input  logic              we_a,
  input  logic              we_b,
  input  logic              read_en,
  input  logic              start,
  input  matmul_pkg::addr_t addr,
  input  matmul_pkg::word_t data_in,
  output matmul_pkg::word_t read_data,
  output logic              done
);

  import matmul_pkg::*;

  logic load_en_q;
  logic we_a_q;
  logic we_b_q;
  logic read_en_q;
  addr_t addr_q;
  word_t data_q;

  addr_t a_addr;
  addr_t b_addr;
  addr_t a_mem_addr;
  addr_t b_mem_addr;
  word_t a_rdata;
  word_t b_rdata;
  word_t a_feed;
  word_t b_feed;
  logic acc_clear;
  logic capture;
  logic write_done;
  elem_t sums [`MATMUL_N * `MATMUL_N];

  // host port, one register stage
  always_ff @(posedge clk) begin
    if (reset) begin
      load_en_q <= 1'b0;
      we_a_q    <= 1'b0;
      we_b_q    <= 1'b0;
      read_en_q <= 1'b0;
    end else begin
      load_en_q <= load_en;
      we_a_q    <= we_a;
      we_b_q    <= we_b;
      read_en_q <= read_en;
    end
  end

  always_ff @(posedge clk) begin
    addr_q <= addr;
    data_q <= data_in;
  end

  // host owns the A/B address while loading
  assign a_mem_addr = load_en_q ? addr_q : a_addr;
  assign b_mem_addr = load_en_q ? addr_q : b_addr;

  word_ram a_ram (
    .clk   (clk),
    .addr  (a_mem_addr),
    .wdata (data_q),
    .we    (we_a_q && load_en_q),
    .rdata (a_rdata)
  );

  word_ram b_ram (
    .clk   (clk),
    .addr  (b_mem_addr),
    .wdata (data_q),
    .we    (we_b_q && load_en_q),
    .rdata (b_rdata)
  );

  operand_decode decode (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .write_done (write_done),
    .a_rdata    (a_rdata),
    .b_rdata    (b_rdata),
    .a_addr     (a_addr),
    .b_addr     (b_addr),
    .a_feed     (a_feed),
    .b_feed     (b_feed),
    .acc_clear  (acc_clear),
    .capture    (capture),
    .done       (done)
  );

  systolic_execute execute (
    .clk       (clk),
    .reset     (reset),
    .acc_clear (acc_clear),
    .a_feed    (a_feed),
    .b_feed    (b_feed),
    .sums      (sums)
  );

  result_store store (
    .clk        (clk),
    .reset      (reset),
    .capture    (capture),
    .sums       (sums),
    .read_en    (read_en_q),
    .host_addr  (addr_q),
    .write_done (write_done),
    .read_data  (read_data)
  );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 8,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- dv/matmul_tb.sv
`timescale 1ns/1ps
`include "matmul_config.svh"

module matmul_tb;

  import matmul_pkg::*;

  localparam int done_timeout = 200;
  localparam int n = `MATMUL_N;

  logic clk;
  logic reset;
  logic load_en;
  logic we_a;
  logic we_b;
  logic read_en;
  logic start;
  addr_t addr;
  word_t data_in;
  word_t read_data;
  logic done;

  elem_t mat_a [n][n];
  elem_t mat_b [n][n];
  logic [15:0] lfsr_state = 16'd29430;

  // read-back words waiting for the compare process
  word_t got_q[$];
  word_t exp_q[$];
  int col_q[$];

  tb_clock clock0 (
    .clk   (clk),
    .reset (reset)
  );

  matmul_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .we_a      (we_a),
    .we_b      (we_b),
    .read_en   (read_en),
    .start     (start),
    .addr      (addr),
    .data_in   (data_in),
    .read_data (read_data),
    .done      (done)
  );

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic elem_t rand_byte();
    elem_t b;
    b = '0;
    for (int bit_n = 0; bit_n < 8; bit_n++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
    return b;
  endfunction

  // C[i][j] is the sum over k of A[i][k] * B[k][j] modulo 256
  function automatic elem_t ref_elem(input int i, input int j);
    elem_t acc;
    acc = '0;
    for (int k = 0; k < n; k++) begin
      acc = acc + elem_t'(mat_a[i][k] * mat_b[k][j]);
    end
    return acc;
  endfunction

  function automatic word_t expected_col(input int j);
    word_t w;
    for (int i = 0; i < n; i++) begin
      w[i] = ref_elem(i, j);
    end
    return w;
  endfunction

  task automatic check_done(input logic exp);
    assert (done === exp) else begin
      $display("** Error: done expected %h, actual %h", exp, done);
      abort_run();
    end
  endtask

  // A word k holds column k of A and B word k holds row k of B
  task automatic load_matrices();
    word_t wa;
    word_t wb;
    load_en = 1'b1;
    for (int k = 0; k < n; k++) begin
      for (int lane = 0; lane < n; lane++) begin
        wa[lane] = mat_a[lane][k];
        wb[lane] = mat_b[k][lane];
      end
      addr = addr_t'(k);
      data_in = wa;
      we_a = 1'b1;
      @(negedge clk);
      we_a = 1'b0;
      data_in = wb;
      we_b = 1'b1;
      @(negedge clk);
      we_b = 1'b0;
    end
    // let the registered host port drain into the memories
    repeat (2) @(negedge clk);
    load_en = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic run_and_wait();
    int cycles;
    cycles = 0;
    start = 1'b1;
    @(negedge clk);
    while (done !== 1'b1) begin
      cycles++;
      if (cycles > done_timeout) begin
        $display("done never came within %0d cycles of start", done_timeout);
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic read_results();
    read_en = 1'b1;
    for (int j = 0; j < n; j++) begin
      addr = addr_t'(j);
      repeat (4) @(negedge clk);
      got_q.push_back(read_data);
      exp_q.push_back(expected_col(j));
      col_q.push_back(j);
    end
    read_en = 1'b0;
    @(negedge clk);
  endtask

  task automatic end_run();
    int cycles;
    cycles = 0;
    start = 1'b0;
    @(negedge clk);
    while (done !== 1'b0) begin
      cycles++;
      if (cycles > 5) begin
        $display("done stayed high after start fell");
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  // words are pushed on the falling edge and compared on the rising edge
  always @(posedge clk) begin : compare
    word_t got;
    word_t exp;
    int col;
    if (got_q.size() > 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      col = col_q.pop_front();
      assert (got === exp) else begin
        $display("** Error: read_data column %0d expected %h, actual %h", col, exp, got);
        abort_run();
      end
    end
  end

  initial begin
    int cycles;
    load_en = 1'b0;
    we_a = 1'b0;
    we_b = 1'b0;
    read_en = 1'b0;
    start = 1'b0;
    addr = '0;
    data_in = '0;

    cycles = 0;
    @(negedge clk);
    while (reset !== 1'b0) begin
      cycles++;
      if (cycles > 20) begin
        $display("reset never released");
        abort_run();
      end
      @(negedge clk);
    end

    // idle after reset
    for (int c = 0; c < 10; c++) begin
      check_done(1'b0);
      @(negedge clk);
    end

    // identity times random B
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        mat_a[i][j] = (i == j) ? elem_t'(1) : elem_t'(0);
        mat_b[i][j] = rand_byte();
      end
    end
    load_matrices();
    run_and_wait();
    read_results();
    end_run();

    // random runs back to back
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < n; i++) begin
        for (int j = 0; j < n; j++) begin
          mat_a[i][j] = rand_byte();
          mat_b[i][j] = rand_byte();
        end
      end
      load_matrices();
      run_and_wait();
      read_results();
      end_run();
    end

    // same operands again so stale sums would double the result
    run_and_wait();
    read_results();
    end_run();

    // all ones bytes wrap to 0x04
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        mat_a[i][j] = 8'hff;
        mat_b[i][j] = 8'hff;
      end
    end
    load_matrices();
    run_and_wait();
    read_results();

    // done holds while start is high and falls after it
    for (int c = 0; c < 10; c++) begin
      check_done(1'b1);
      @(negedge clk);
    end
    end_run();
    repeat (3) @(negedge clk);

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- list.f
+incdir+design
design/matmul_pkg.sv
design/word_ram.sv
design/operand_decode.sv
design/mac_pe.sv
design/systolic_execute.sv
design/result_store.sv
design/matmul_top.sv
dv/tb_clock.sv
dv/matmul_tb.sv
